//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [4:0] reg_addr_t;

	localparam reg_addr_t REG_ZERO = 5'd0;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fields_t;

	// Both views cover the whole word, the opcode tells which one applies
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

	typedef enum logic [5:0] {
		KIND_UNKNOWN,
		KIND_ADDU, KIND_SUBU, KIND_ADD, KIND_SUB, KIND_AND, KIND_OR,
		KIND_NOR, KIND_XOR, KIND_SLT, KIND_SLTU, KIND_SLL, KIND_SRL,
		KIND_SRA, KIND_SLLV, KIND_SRLV, KIND_SRAV,
		KIND_LUI, KIND_ORI, KIND_ADDI, KIND_ADDIU, KIND_ANDI, KIND_XORI,
		KIND_SLTI, KIND_SLTIU,
		KIND_LW, KIND_LH, KIND_LHU, KIND_LB, KIND_LBU,
		KIND_SW, KIND_SH, KIND_SB
	} instr_kind_t;

	typedef enum logic [2:0] {
		CLS_NONE,
		CLS_CAL_R,
		CLS_CAL_I,
		CLS_LOAD,
		CLS_STORE
	} instr_class_t;

	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_LHU     = 6'b100101;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LBU     = 6'b100100;
	localparam logic [5:0] OP_SW      = 6'b101011;
	localparam logic [5:0] OP_SH      = 6'b101001;
	localparam logic [5:0] OP_SB      = 6'b101000;

	localparam logic [5:0] FUNCT_ADDU = 6'b100001;
	localparam logic [5:0] FUNCT_SUBU = 6'b100011;
	localparam logic [5:0] FUNCT_ADD  = 6'b100000;
	localparam logic [5:0] FUNCT_SUB  = 6'b100010;
	localparam logic [5:0] FUNCT_AND  = 6'b100100;
	localparam logic [5:0] FUNCT_OR   = 6'b100101;
	localparam logic [5:0] FUNCT_NOR  = 6'b100111;
	localparam logic [5:0] FUNCT_XOR  = 6'b100110;
	localparam logic [5:0] FUNCT_SLT  = 6'b101010;
	localparam logic [5:0] FUNCT_SLTU = 6'b101011;
	localparam logic [5:0] FUNCT_SLL  = 6'b000000;
	localparam logic [5:0] FUNCT_SRL  = 6'b000010;
	localparam logic [5:0] FUNCT_SRA  = 6'b000011;
	localparam logic [5:0] FUNCT_SLLV = 6'b000100;
	localparam logic [5:0] FUNCT_SRLV = 6'b000110;
	localparam logic [5:0] FUNCT_SRAV = 6'b000111;

endpackage

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	typedef enum logic [4:0] {
		ALU_ADDU,
		ALU_SUBU,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLLV,
		ALU_SRLV,
		ALU_SRAV
	} alu_op_t;

	typedef enum logic [1:0] {
		EXT_SIGNED   = 2'd0,
		EXT_UNSIGNED = 2'd1,
		EXT_PAD      = 2'd2 // Immediate lands in the upper half, low half zero
	} ext_mode_t;

	typedef enum logic [2:0] {
		DM_NONE = 3'd0,
		DM_W    = 3'd1,
		DM_H    = 3'd2,
		DM_HU   = 3'd3,
		DM_B    = 3'd4,
		DM_BU   = 3'd5
	} dm_mode_t;

	typedef enum logic [1:0] {
		RD_NONE = 2'd0,
		RD_ALU  = 2'd1,
		RD_MEM  = 2'd2
	} regdata_sel_t;

	typedef enum logic [1:0] {
		FWD_RF = 2'd0, // Value read from the register file in D
		FWD_M  = 2'd1,
		FWD_W  = 2'd2
	} fwd_sel_t;

endpackage

`default_nettype wire

//--- hdl/instr_classifier.sv
`default_nettype none

module instr_classifier (
	input  wire isa_pkg::instr_t instr,
	output isa_pkg::instr_kind_t kind,
	output isa_pkg::instr_class_t cls
);

	isa_pkg::instr_kind_t r_kind;
	isa_pkg::instr_kind_t i_kind;
	logic rs_zero;
	logic shamt_zero;
	logic shift_const;
	logic r_fields_ok;

	assign rs_zero = (instr.r.rs == isa_pkg::REG_ZERO);
	assign shamt_zero = (instr.r.shamt == 5'd0);

	// Constant shifts carry the amount in shamt and leave rs unused
	assign shift_const = (instr.r.funct == isa_pkg::FUNCT_SLL) ||
		(instr.r.funct == isa_pkg::FUNCT_SRL) ||
		(instr.r.funct == isa_pkg::FUNCT_SRA);
	assign r_fields_ok = shift_const ? rs_zero : shamt_zero;

	always_comb begin
		case (instr.r.funct)
			isa_pkg::FUNCT_ADDU: r_kind = isa_pkg::KIND_ADDU;
			isa_pkg::FUNCT_SUBU: r_kind = isa_pkg::KIND_SUBU;
			isa_pkg::FUNCT_ADD:  r_kind = isa_pkg::KIND_ADD;
			isa_pkg::FUNCT_SUB:  r_kind = isa_pkg::KIND_SUB;
			isa_pkg::FUNCT_AND:  r_kind = isa_pkg::KIND_AND;
			isa_pkg::FUNCT_OR:   r_kind = isa_pkg::KIND_OR;
			isa_pkg::FUNCT_NOR:  r_kind = isa_pkg::KIND_NOR;
			isa_pkg::FUNCT_XOR:  r_kind = isa_pkg::KIND_XOR;
			isa_pkg::FUNCT_SLT:  r_kind = isa_pkg::KIND_SLT;
			isa_pkg::FUNCT_SLTU: r_kind = isa_pkg::KIND_SLTU;
			isa_pkg::FUNCT_SLL:  r_kind = isa_pkg::KIND_SLL;
			isa_pkg::FUNCT_SRL:  r_kind = isa_pkg::KIND_SRL;
			isa_pkg::FUNCT_SRA:  r_kind = isa_pkg::KIND_SRA;
			isa_pkg::FUNCT_SLLV: r_kind = isa_pkg::KIND_SLLV;
			isa_pkg::FUNCT_SRLV: r_kind = isa_pkg::KIND_SRLV;
			isa_pkg::FUNCT_SRAV: r_kind = isa_pkg::KIND_SRAV;
			default:             r_kind = isa_pkg::KIND_UNKNOWN;
		endcase
	end

	always_comb begin
		case (instr.i.opcode)
			isa_pkg::OP_LUI:   i_kind = isa_pkg::KIND_LUI;
			isa_pkg::OP_ORI:   i_kind = isa_pkg::KIND_ORI;
			isa_pkg::OP_ADDI:  i_kind = isa_pkg::KIND_ADDI;
			isa_pkg::OP_ADDIU: i_kind = isa_pkg::KIND_ADDIU;
			isa_pkg::OP_ANDI:  i_kind = isa_pkg::KIND_ANDI;
			isa_pkg::OP_XORI:  i_kind = isa_pkg::KIND_XORI;
			isa_pkg::OP_SLTI:  i_kind = isa_pkg::KIND_SLTI;
			isa_pkg::OP_SLTIU: i_kind = isa_pkg::KIND_SLTIU;
			isa_pkg::OP_LW:    i_kind = isa_pkg::KIND_LW;
			isa_pkg::OP_LH:    i_kind = isa_pkg::KIND_LH;
			isa_pkg::OP_LHU:   i_kind = isa_pkg::KIND_LHU;
			isa_pkg::OP_LB:    i_kind = isa_pkg::KIND_LB;
			isa_pkg::OP_LBU:   i_kind = isa_pkg::KIND_LBU;
			isa_pkg::OP_SW:    i_kind = isa_pkg::KIND_SW;
			isa_pkg::OP_SH:    i_kind = isa_pkg::KIND_SH;
			isa_pkg::OP_SB:    i_kind = isa_pkg::KIND_SB;
			default:           i_kind = isa_pkg::KIND_UNKNOWN;
		endcase
	end

	always_comb begin
		kind = isa_pkg::KIND_UNKNOWN;
		cls = isa_pkg::CLS_NONE;
		if (instr.i.opcode == isa_pkg::OP_SPECIAL) begin
			if (r_kind != isa_pkg::KIND_UNKNOWN && r_fields_ok) begin
				kind = r_kind;
				cls = isa_pkg::CLS_CAL_R;
			end
		end else if (i_kind != isa_pkg::KIND_UNKNOWN &&
				!(i_kind == isa_pkg::KIND_LUI && !rs_zero)) begin
			kind = i_kind;
			// The top three opcode bits group the I-format instructions
			case (instr.i.opcode[5:3])
				3'b001:  cls = isa_pkg::CLS_CAL_I;
				3'b100:  cls = isa_pkg::CLS_LOAD;
				3'b101:  cls = isa_pkg::CLS_STORE;
				default: cls = isa_pkg::CLS_NONE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/decode_ctrl.sv
`default_nettype none

module decode_ctrl (
	input  wire isa_pkg::instr_t instr,
	input  wire isa_pkg::instr_kind_t kind,
	input  wire isa_pkg::instr_class_t cls,
	output isa_pkg::reg_addr_t reg1,
	output isa_pkg::reg_addr_t reg2,
	output isa_pkg::reg_addr_t regw,
	output ctrl_pkg::ext_mode_t ext_mode
);

	// Every kept class reads rs, a bubble reads nothing
	always_comb begin
		case (cls)
			isa_pkg::CLS_CAL_R,
			isa_pkg::CLS_CAL_I,
			isa_pkg::CLS_LOAD,
			isa_pkg::CLS_STORE: reg1 = instr.i.rs;
			default:            reg1 = isa_pkg::REG_ZERO;
		endcase
	end

	always_comb begin
		case (cls)
			isa_pkg::CLS_CAL_R,
			isa_pkg::CLS_STORE: reg2 = instr.i.rt; // Store data comes through rt
			default:            reg2 = isa_pkg::REG_ZERO;
		endcase
	end

	always_comb begin
		case (cls)
			isa_pkg::CLS_CAL_R: regw = instr.r.rd;
			isa_pkg::CLS_CAL_I,
			isa_pkg::CLS_LOAD:  regw = instr.i.rt;
			default:            regw = isa_pkg::REG_ZERO; // Stores and bubbles write nothing
		endcase
	end

	always_comb begin
		case (kind)
			isa_pkg::KIND_LUI:  ext_mode = ctrl_pkg::EXT_PAD;
			isa_pkg::KIND_ORI,
			isa_pkg::KIND_ANDI,
			isa_pkg::KIND_XORI: ext_mode = ctrl_pkg::EXT_UNSIGNED; // Logic ops zero-extend
			default:            ext_mode = ctrl_pkg::EXT_SIGNED;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/stage_pipe.sv
`default_nettype none

module stage_pipe (
	input  wire clk,
	input  wire rst_n,
	input  wire stall,
	input  wire isa_pkg::instr_kind_t d_kind,
	input  wire isa_pkg::instr_class_t d_class,
	input  wire isa_pkg::reg_addr_t d_reg1,
	input  wire isa_pkg::reg_addr_t d_reg2,
	input  wire isa_pkg::reg_addr_t d_regw,
	output isa_pkg::instr_kind_t e_kind,
	output isa_pkg::instr_class_t e_class,
	output isa_pkg::reg_addr_t e_reg1,
	output isa_pkg::reg_addr_t e_reg2,
	output isa_pkg::reg_addr_t e_regw,
	output isa_pkg::instr_kind_t m_kind,
	output isa_pkg::instr_class_t m_class,
	output isa_pkg::reg_addr_t m_regw,
	output isa_pkg::instr_kind_t w_kind,
	output isa_pkg::instr_class_t w_class,
	output isa_pkg::reg_addr_t w_regw
);

	// A stalled D instruction stays put, so E takes a bubble in its place
	always_ff @(posedge clk) begin
		if (!rst_n || stall) begin
			e_kind <= isa_pkg::KIND_UNKNOWN;
			e_class <= isa_pkg::CLS_NONE;
			e_reg1 <= isa_pkg::REG_ZERO;
			e_reg2 <= isa_pkg::REG_ZERO;
			e_regw <= isa_pkg::REG_ZERO;
		end else begin
			e_kind <= d_kind;
			e_class <= d_class;
			e_reg1 <= d_reg1;
			e_reg2 <= d_reg2;
			e_regw <= d_regw;
		end
	end

	// Source registers are only compared in E, so M and W keep the destination
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_kind <= isa_pkg::KIND_UNKNOWN;
			m_class <= isa_pkg::CLS_NONE;
			m_regw <= isa_pkg::REG_ZERO;
			w_kind <= isa_pkg::KIND_UNKNOWN;
			w_class <= isa_pkg::CLS_NONE;
			w_regw <= isa_pkg::REG_ZERO;
		end else begin
			m_kind <= e_kind;
			m_class <= e_class;
			m_regw <= e_regw;
			w_kind <= m_kind;
			w_class <= m_class;
			w_regw <= m_regw;
		end
	end

	// An unknown word decodes to zero registers, so bubbles never take part in hazards
	a_bubble_regs_zero: assert property (@(posedge clk) disable iff (!rst_n)
		e_class == isa_pkg::CLS_NONE |-> (e_reg1 == isa_pkg::REG_ZERO &&
		e_reg2 == isa_pkg::REG_ZERO && e_regw == isa_pkg::REG_ZERO));

endmodule

`default_nettype wire

//--- hdl/late_stage_ctrl.sv
`default_nettype none

module late_stage_ctrl (
	input  wire isa_pkg::instr_kind_t e_kind,
	input  wire isa_pkg::instr_class_t e_class,
	input  wire isa_pkg::instr_kind_t m_kind,
	input  wire isa_pkg::instr_class_t m_class,
	input  wire isa_pkg::instr_class_t w_class,
	output ctrl_pkg::alu_op_t alu_op,
	output logic alu_src,
	output logic dm_write_enable,
	output ctrl_pkg::dm_mode_t dm_mode,
	output logic rf_write_enable,
	output ctrl_pkg::regdata_sel_t regdata_sel
);

	always_comb begin
		case (e_kind)
			isa_pkg::KIND_ADDU:  alu_op = ctrl_pkg::ALU_ADDU;
			isa_pkg::KIND_SUBU:  alu_op = ctrl_pkg::ALU_SUBU;
			isa_pkg::KIND_ADD:   alu_op = ctrl_pkg::ALU_ADD;
			isa_pkg::KIND_SUB:   alu_op = ctrl_pkg::ALU_SUB;
			isa_pkg::KIND_AND:   alu_op = ctrl_pkg::ALU_AND;
			isa_pkg::KIND_NOR:   alu_op = ctrl_pkg::ALU_NOR;
			isa_pkg::KIND_XOR:   alu_op = ctrl_pkg::ALU_XOR;
			isa_pkg::KIND_SLT:   alu_op = ctrl_pkg::ALU_SLT;
			isa_pkg::KIND_SLTU:  alu_op = ctrl_pkg::ALU_SLTU;
			isa_pkg::KIND_SLL:   alu_op = ctrl_pkg::ALU_SLL;
			isa_pkg::KIND_SRL:   alu_op = ctrl_pkg::ALU_SRL;
			isa_pkg::KIND_SRA:   alu_op = ctrl_pkg::ALU_SRA;
			isa_pkg::KIND_SLLV:  alu_op = ctrl_pkg::ALU_SLLV;
			isa_pkg::KIND_SRLV:  alu_op = ctrl_pkg::ALU_SRLV;
			isa_pkg::KIND_SRAV:  alu_op = ctrl_pkg::ALU_SRAV;
			isa_pkg::KIND_ADDI:  alu_op = ctrl_pkg::ALU_ADD;
			isa_pkg::KIND_ADDIU: alu_op = ctrl_pkg::ALU_ADDU;
			isa_pkg::KIND_ANDI:  alu_op = ctrl_pkg::ALU_AND;
			isa_pkg::KIND_XORI:  alu_op = ctrl_pkg::ALU_XOR;
			isa_pkg::KIND_SLTI:  alu_op = ctrl_pkg::ALU_SLT;
			isa_pkg::KIND_SLTIU: alu_op = ctrl_pkg::ALU_SLTU;
			isa_pkg::KIND_LW,
			isa_pkg::KIND_LH,
			isa_pkg::KIND_LHU,
			isa_pkg::KIND_LB,
			isa_pkg::KIND_LBU,
			isa_pkg::KIND_SW,
			isa_pkg::KIND_SH,
			isa_pkg::KIND_SB:    alu_op = ctrl_pkg::ALU_ADD; // Base plus offset
			default:             alu_op = ctrl_pkg::ALU_OR; // Also LUI, which ORs the padded value with r0
		endcase
	end

	assign alu_src = (e_class == isa_pkg::CLS_CAL_I) || (e_class == isa_pkg::CLS_LOAD) ||
		(e_class == isa_pkg::CLS_STORE);

	always_comb begin
		case (m_kind)
			isa_pkg::KIND_LW,
			isa_pkg::KIND_SW:  dm_mode = ctrl_pkg::DM_W;
			isa_pkg::KIND_LH,
			isa_pkg::KIND_SH:  dm_mode = ctrl_pkg::DM_H;
			isa_pkg::KIND_LHU: dm_mode = ctrl_pkg::DM_HU;
			isa_pkg::KIND_LB,
			isa_pkg::KIND_SB:  dm_mode = ctrl_pkg::DM_B;
			isa_pkg::KIND_LBU: dm_mode = ctrl_pkg::DM_BU;
			default:           dm_mode = ctrl_pkg::DM_NONE;
		endcase
	end

	assign dm_write_enable = (m_class == isa_pkg::CLS_STORE);

	always_comb begin
		case (w_class)
			isa_pkg::CLS_CAL_R,
			isa_pkg::CLS_CAL_I: regdata_sel = ctrl_pkg::RD_ALU;
			isa_pkg::CLS_LOAD:  regdata_sel = ctrl_pkg::RD_MEM;
			default:            regdata_sel = ctrl_pkg::RD_NONE;
		endcase
	end

	assign rf_write_enable = (regdata_sel != ctrl_pkg::RD_NONE); // Exactly the writing classes

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input  wire clk,
	input  wire rst_n,
	input  wire isa_pkg::reg_addr_t d_reg1,
	input  wire isa_pkg::reg_addr_t d_reg2,
	input  wire isa_pkg::reg_addr_t e_reg1,
	input  wire isa_pkg::reg_addr_t e_reg2,
	input  wire isa_pkg::reg_addr_t e_regw,
	input  wire isa_pkg::reg_addr_t m_regw,
	input  wire isa_pkg::reg_addr_t w_regw,
	input  wire isa_pkg::instr_class_t e_class,
	input  wire isa_pkg::instr_class_t m_class,
	output logic stall,
	output ctrl_pkg::fwd_sel_t fwd_e1,
	output ctrl_pkg::fwd_sel_t fwd_e2
);

	// Load data only exists after M, so a dependent instruction must wait one cycle
	assign stall = (e_class == isa_pkg::CLS_LOAD) && (e_regw != isa_pkg::REG_ZERO) &&
		((e_regw == d_reg1) || (e_regw == d_reg2));

	// The youngest producer wins, and r0 is never forwarded
	function automatic ctrl_pkg::fwd_sel_t pick_fwd(input isa_pkg::reg_addr_t src,
			input isa_pkg::reg_addr_t m_dst, input isa_pkg::instr_class_t m_cls,
			input isa_pkg::reg_addr_t w_dst);
		if (src == isa_pkg::REG_ZERO)
			return ctrl_pkg::FWD_RF;
		if (src == m_dst && m_cls != isa_pkg::CLS_LOAD)
			return ctrl_pkg::FWD_M;
		if (src == w_dst)
			return ctrl_pkg::FWD_W;
		return ctrl_pkg::FWD_RF;
	endfunction

	assign fwd_e1 = pick_fwd(e_reg1, m_regw, m_class, w_regw);
	assign fwd_e2 = pick_fwd(e_reg2, m_regw, m_class, w_regw);

	// The stall one cycle earlier keeps a consumer out of E while its load sits in M
	a_no_load_fwd_from_m: assert property (@(posedge clk) disable iff (!rst_n)
		(m_class == isa_pkg::CLS_LOAD && m_regw != isa_pkg::REG_ZERO) |->
		(e_reg1 != m_regw && e_reg2 != m_regw));

endmodule

`default_nettype wire

//--- hdl/pipe_control.sv
`default_nettype none

module pipe_control (
	input  wire clk,
	input  wire rst_n,
	input  wire [31:0] d_instr,
	output logic stall,
	output ctrl_pkg::ext_mode_t ext_mode,
	output isa_pkg::reg_addr_t rf_read_addr1,
	output isa_pkg::reg_addr_t rf_read_addr2,
	output ctrl_pkg::alu_op_t alu_op,
	output logic alu_src,
	output ctrl_pkg::fwd_sel_t fwd_e1,
	output ctrl_pkg::fwd_sel_t fwd_e2,
	output logic dm_write_enable,
	output ctrl_pkg::dm_mode_t dm_mode,
	output logic rf_write_enable,
	output ctrl_pkg::regdata_sel_t regdata_sel,
	output isa_pkg::reg_addr_t rf_write_addr
);

	isa_pkg::instr_kind_t d_kind;
	isa_pkg::instr_class_t d_class;
	isa_pkg::reg_addr_t d_reg1;
	isa_pkg::reg_addr_t d_reg2;
	isa_pkg::reg_addr_t d_regw;
	isa_pkg::instr_kind_t e_kind;
	isa_pkg::instr_class_t e_class;
	isa_pkg::reg_addr_t e_reg1;
	isa_pkg::reg_addr_t e_reg2;
	isa_pkg::reg_addr_t e_regw;
	isa_pkg::instr_kind_t m_kind;
	isa_pkg::instr_class_t m_class;
	isa_pkg::reg_addr_t m_regw;
	isa_pkg::instr_class_t w_class;
	isa_pkg::reg_addr_t w_regw;

	instr_classifier i_instr_classifier (
		.instr (d_instr),
		.kind  (d_kind),
		.cls   (d_class)
	);

	decode_ctrl i_decode_ctrl (
		.instr    (d_instr),
		.kind     (d_kind),
		.cls      (d_class),
		.reg1     (d_reg1),
		.reg2     (d_reg2),
		.regw     (d_regw),
		.ext_mode (ext_mode)
	);

	// The register file is read with the decoded sources, zero when a field is unused
	assign rf_read_addr1 = d_reg1;
	assign rf_read_addr2 = d_reg2;

	stage_pipe i_stage_pipe (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.d_kind  (d_kind),
		.d_class (d_class),
		.d_reg1  (d_reg1),
		.d_reg2  (d_reg2),
		.d_regw  (d_regw),
		.e_kind  (e_kind),
		.e_class (e_class),
		.e_reg1  (e_reg1),
		.e_reg2  (e_reg2),
		.e_regw  (e_regw),
		.m_kind  (m_kind),
		.m_class (m_class),
		.m_regw  (m_regw),
		.w_kind  (), // W controls depend on the class alone
		.w_class (w_class),
		.w_regw  (w_regw)
	);

	assign rf_write_addr = w_regw;

	late_stage_ctrl i_late_stage_ctrl (
		.e_kind          (e_kind),
		.e_class         (e_class),
		.m_kind          (m_kind),
		.m_class         (m_class),
		.w_class         (w_class),
		.alu_op          (alu_op),
		.alu_src         (alu_src),
		.dm_write_enable (dm_write_enable),
		.dm_mode         (dm_mode),
		.rf_write_enable (rf_write_enable),
		.regdata_sel     (regdata_sel)
	);

	hazard_unit i_hazard_unit (
		.clk     (clk),
		.rst_n   (rst_n),
		.d_reg1  (d_reg1),
		.d_reg2  (d_reg2),
		.e_reg1  (e_reg1),
		.e_reg2  (e_reg2),
		.e_regw  (e_regw),
		.m_regw  (m_regw),
		.w_regw  (w_regw),
		.e_class (e_class),
		.m_class (m_class),
		.stall   (stall),
		.fwd_e1  (fwd_e1),
		.fwd_e2  (fwd_e2)
	);

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // Half of the 4-unit period
	end

	// Reset is released on the edge that ends the tenth cycle
	initial begin
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/tb_pipe_control.sv
`default_nettype none

module tb_pipe_control;

	localparam int CLK_PERIOD = 4;
	localparam logic [31:0] IDLE_WORD = 32'hfc00_0000; // Opcode 111111 is not defined
	localparam logic [4:0] F_RS1 = 5'd1; // rs takes the destination of the entry before
	localparam logic [4:0] F_RT1 = 5'd2;
	localparam logic [4:0] F_RT2 = 5'd4; // rt takes the destination from two entries back
	localparam logic [4:0] F_RT0 = 5'd8;
	localparam logic [4:0] F_BAD_RS = 5'd16; // Nonzero rs where the field must be zero

	typedef struct packed {
		logic [5:0] opcode;
		logic [5:0] funct;
		logic [4:0] shamt;
		logic [4:0] flags;
		logic [2:0] cls;
		logic [4:0] alu;
		logic [1:0] ext;
		logic [2:0] dm;
	} entry_t;

	// One instruction as the model sees it on its way through the stages
	typedef struct packed {
		logic       live;
		logic [7:0] idx;
		logic [2:0] cls;
		logic [4:0] alu;
		logic [1:0] ext;
		logic [2:0] dm;
		logic [4:0] reg1;
		logic [4:0] reg2;
		logic [4:0] regw;
	} slot_t;

	localparam slot_t BUBBLE = '0;

	wire clk;
	wire rst_n;
	logic [31:0] d_instr;
	wire stall;
	wire [1:0] ext_mode;
	wire [4:0] rf_read_addr1;
	wire [4:0] rf_read_addr2;
	wire [4:0] alu_op;
	wire alu_src;
	wire [1:0] fwd_e1;
	wire [1:0] fwd_e2;
	wire dm_write_enable;
	wire [2:0] dm_mode;
	wire rf_write_enable;
	wire [1:0] regdata_sel;
	wire [4:0] rf_write_addr;

	entry_t tbl [$];
	logic [31:0] words [$];
	int entry_err [$];
	logic [31:0] lfsr = 32'h6b81_e54b;
	slot_t sd;
	slot_t se;
	slot_t sm;
	slot_t sw;
	slot_t next_e;
	logic exp_stall;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	pipe_control i_pipe_control (
		.clk             (clk),
		.rst_n           (rst_n),
		.d_instr         (d_instr),
		.stall           (stall),
		.ext_mode        (ext_mode),
		.rf_read_addr1   (rf_read_addr1),
		.rf_read_addr2   (rf_read_addr2),
		.alu_op          (alu_op),
		.alu_src         (alu_src),
		.fwd_e1          (fwd_e1),
		.fwd_e2          (fwd_e2),
		.dm_write_enable (dm_write_enable),
		.dm_mode         (dm_mode),
		.rf_write_enable (rf_write_enable),
		.regdata_sel     (regdata_sel),
		.rf_write_addr   (rf_write_addr)
	);

	// The Galois LFSR takes one step per bit handed out
	function automatic logic [15:0] next_rand_bits(input int n);
		logic [15:0] bits;
		logic lsb;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lsb = lfsr[0];
			lfsr = (lfsr >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
			bits = {bits[14:0], lsb};
		end
		return bits;
	endfunction

	task automatic add_row(input logic [5:0] opcode, input logic [5:0] funct,
			input logic [4:0] shamt, input logic [4:0] flags, input logic [2:0] cls,
			input logic [4:0] alu, input logic [1:0] ext, input logic [2:0] dm);
		entry_t e;
		e.opcode = opcode;
		e.funct = funct;
		e.shamt = shamt;
		e.flags = flags;
		e.cls = cls;
		e.alu = alu;
		e.ext = ext;
		e.dm = dm;
		tbl.push_back(e);
	endtask

	task automatic add_r(input logic [5:0] funct, input logic [4:0] shamt,
			input logic [4:0] flags, input logic [4:0] alu);
		add_row(isa_pkg::OP_SPECIAL, funct, shamt, flags, isa_pkg::CLS_CAL_R, alu,
			ctrl_pkg::EXT_SIGNED, ctrl_pkg::DM_NONE);
	endtask

	task automatic add_cal_i(input logic [5:0] opcode, input logic [4:0] flags,
			input logic [4:0] alu, input logic [1:0] ext);
		add_row(opcode, 6'd0, 5'd0, flags, isa_pkg::CLS_CAL_I, alu, ext, ctrl_pkg::DM_NONE);
	endtask

	// Loads and stores always compute base plus signed offset
	task automatic add_mem(input logic [5:0] opcode, input logic [4:0] flags,
			input logic [2:0] cls, input logic [2:0] dm);
		add_row(opcode, 6'd0, 5'd0, flags, cls, ctrl_pkg::ALU_ADD, ctrl_pkg::EXT_SIGNED, dm);
	endtask

	task automatic add_bad(input logic [5:0] opcode, input logic [5:0] funct,
			input logic [4:0] shamt, input logic [4:0] flags);
		add_row(opcode, funct, shamt, flags, isa_pkg::CLS_NONE, ctrl_pkg::ALU_OR,
			ctrl_pkg::EXT_SIGNED, ctrl_pkg::DM_NONE);
	endtask

	// Fills the register fields and applies the forced dependences of a row
	function automatic logic [31:0] build_word(input entry_t e, input logic [4:0] dst1,
			input logic [4:0] dst2);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		logic rs_unused;
		rs = 5'(next_rand_bits(5));
		rt = 5'(next_rand_bits(5));
		rd = 5'(next_rand_bits(5));
		imm = (e.opcode == isa_pkg::OP_SPECIAL) ? 16'h0 : next_rand_bits(16);
		rt = (rt == 5'd0) ? 5'd1 : rt; // Zero targets appear only where a row asks for them
		rd = (rd == 5'd0) ? 5'd1 : rd;
		if ((e.flags & F_RS1) != 0)
			rs = dst1;
		if ((e.flags & F_RT1) != 0)
			rt = dst1;
		if ((e.flags & F_RT2) != 0)
			rt = dst2;
		if ((e.flags & F_RT0) != 0)
			rt = 5'd0;
		rs_unused = (e.opcode == isa_pkg::OP_LUI) || (e.opcode == isa_pkg::OP_SPECIAL &&
			(e.funct == isa_pkg::FUNCT_SLL || e.funct == isa_pkg::FUNCT_SRL ||
			e.funct == isa_pkg::FUNCT_SRA));
		if ((e.flags & F_BAD_RS) != 0)
			rs = (rs == 5'd0) ? 5'd3 : rs;
		else if (rs_unused)
			rs = 5'd0;
		if (e.opcode == isa_pkg::OP_SPECIAL)
			return {e.opcode, rs, rt, rd, e.shamt, e.funct};
		return {e.opcode, rs, rt, imm};
	endfunction

	function automatic slot_t decode_slot(input entry_t e, input logic [31:0] word,
			input int idx);
		slot_t s;
		s = BUBBLE;
		s.live = 1'b1;
		s.idx = 8'(idx);
		s.cls = e.cls;
		s.alu = e.alu;
		s.ext = e.ext;
		s.dm = e.dm;
		if (e.cls != isa_pkg::CLS_NONE)
			s.reg1 = word[25:21];
		if (e.cls == isa_pkg::CLS_CAL_R || e.cls == isa_pkg::CLS_STORE)
			s.reg2 = word[20:16];
		if (e.cls == isa_pkg::CLS_CAL_R)
			s.regw = word[15:11];
		else if (e.cls == isa_pkg::CLS_CAL_I || e.cls == isa_pkg::CLS_LOAD)
			s.regw = word[20:16];
		return s;
	endfunction

	// Closest producer first, loads in M have no data yet
	function automatic logic [1:0] expect_fwd(input logic [4:0] src);
		if (src == 5'd0)
			return ctrl_pkg::FWD_RF;
		else if (src == sm.regw && sm.cls != isa_pkg::CLS_LOAD)
			return ctrl_pkg::FWD_M;
		else if (src == sw.regw)
			return ctrl_pkg::FWD_W;
		return ctrl_pkg::FWD_RF;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
			input slot_t s);
		int tag;
		tag = s.live ? int'(s.idx) : -1;
		assert (got === exp) else begin
			$display("Mismatch %s: got 0x%h, expected 0x%h (test %0d)", name, got, exp, tag);
			errors++;
			if (s.live)
				entry_err[s.idx]++;
		end
	endtask

	task automatic compare_outputs();
		logic writes;
		logic [1:0] rd_exp;
		check("ext_mode", 32'(ext_mode), 32'(sd.ext), sd);
		check("rf_read_addr1", 32'(rf_read_addr1), 32'(sd.reg1), sd);
		check("rf_read_addr2", 32'(rf_read_addr2), 32'(sd.reg2), sd);
		check("stall", 32'(stall), 32'(exp_stall), sd);
		if (se.cls != isa_pkg::CLS_NONE)
			check("alu_op", 32'(alu_op), 32'(se.alu), se);
		check("alu_src", 32'(alu_src), 32'(se.cls == isa_pkg::CLS_CAL_I ||
			se.cls == isa_pkg::CLS_LOAD || se.cls == isa_pkg::CLS_STORE), se);
		check("fwd_e1", 32'(fwd_e1), 32'(expect_fwd(se.reg1)), se);
		check("fwd_e2", 32'(fwd_e2), 32'(expect_fwd(se.reg2)), se);
		check("dm_write_enable", 32'(dm_write_enable), 32'(sm.cls == isa_pkg::CLS_STORE), sm);
		check("dm_mode", 32'(dm_mode), 32'(sm.dm), sm);
		writes = (sw.cls == isa_pkg::CLS_CAL_R) || (sw.cls == isa_pkg::CLS_CAL_I) ||
			(sw.cls == isa_pkg::CLS_LOAD);
		if (!writes)
			rd_exp = ctrl_pkg::RD_NONE;
		else if (sw.cls == isa_pkg::CLS_LOAD)
			rd_exp = ctrl_pkg::RD_MEM;
		else
			rd_exp = ctrl_pkg::RD_ALU;
		check("rf_write_enable", 32'(rf_write_enable), 32'(writes), sw);
		check("regdata_sel", 32'(regdata_sel), 32'(rd_exp), sw);
		check("rf_write_addr", 32'(rf_write_addr), 32'(sw.regw), sw);
		if (sw.live) begin // The instruction leaves W, so its test is complete
			tests_run++;
			if (entry_err[sw.idx] == 0) begin
				$display("test %0d (%h): ok", sw.idx, words[sw.idx]);
			end else begin
				tests_failed++;
				$display("test %0d (%h): FAIL, %0d errors", sw.idx, words[sw.idx],
					entry_err[sw.idx]);
			end
		end
	endtask

	initial begin
		int i;
		int drain;
		int reset_err;
		logic held;
		logic [4:0] dst1;
		logic [4:0] dst2;
		d_instr <= IDLE_WORD;

		add_r(isa_pkg::FUNCT_ADDU, 5'd0, 5'd0, ctrl_pkg::ALU_ADDU);
		add_r(isa_pkg::FUNCT_SUBU, 5'd0, F_RS1, ctrl_pkg::ALU_SUBU); // rs from M
		add_r(isa_pkg::FUNCT_ADD, 5'd0, F_RT2, ctrl_pkg::ALU_ADD); // rt from W
		add_r(isa_pkg::FUNCT_SUB, 5'd0, F_RS1 | F_RT2, ctrl_pkg::ALU_SUB);
		add_r(isa_pkg::FUNCT_AND, 5'd0, 5'd0, ctrl_pkg::ALU_AND);
		add_r(isa_pkg::FUNCT_OR, 5'd0, F_RT1, ctrl_pkg::ALU_OR);
		add_r(isa_pkg::FUNCT_NOR, 5'd0, 5'd0, ctrl_pkg::ALU_NOR);
		add_r(isa_pkg::FUNCT_XOR, 5'd0, 5'd0, ctrl_pkg::ALU_XOR);
		add_r(isa_pkg::FUNCT_SLT, 5'd0, F_RS1, ctrl_pkg::ALU_SLT);
		add_r(isa_pkg::FUNCT_SLTU, 5'd0, 5'd0, ctrl_pkg::ALU_SLTU);
		add_r(isa_pkg::FUNCT_SLL, 5'd7, 5'd0, ctrl_pkg::ALU_SLL);
		add_r(isa_pkg::FUNCT_SRL, 5'd7, F_RT1, ctrl_pkg::ALU_SRL);
		add_r(isa_pkg::FUNCT_SRA, 5'd7, 5'd0, ctrl_pkg::ALU_SRA);
		add_r(isa_pkg::FUNCT_SLLV, 5'd0, 5'd0, ctrl_pkg::ALU_SLLV);
		add_r(isa_pkg::FUNCT_SRLV, 5'd0, F_RS1, ctrl_pkg::ALU_SRLV);
		add_r(isa_pkg::FUNCT_SRAV, 5'd0, 5'd0, ctrl_pkg::ALU_SRAV);
		add_cal_i(isa_pkg::OP_LUI, 5'd0, ctrl_pkg::ALU_OR, ctrl_pkg::EXT_PAD);
		add_cal_i(isa_pkg::OP_ORI, F_RS1, ctrl_pkg::ALU_OR, ctrl_pkg::EXT_UNSIGNED);
		add_cal_i(isa_pkg::OP_ADDI, 5'd0, ctrl_pkg::ALU_ADD, ctrl_pkg::EXT_SIGNED);
		add_cal_i(isa_pkg::OP_ADDIU, F_RS1, ctrl_pkg::ALU_ADDU, ctrl_pkg::EXT_SIGNED);
		add_cal_i(isa_pkg::OP_ANDI, 5'd0, ctrl_pkg::ALU_AND, ctrl_pkg::EXT_UNSIGNED);
		add_cal_i(isa_pkg::OP_XORI, 5'd0, ctrl_pkg::ALU_XOR, ctrl_pkg::EXT_UNSIGNED);
		add_cal_i(isa_pkg::OP_SLTI, 5'd0, ctrl_pkg::ALU_SLT, ctrl_pkg::EXT_SIGNED);
		add_cal_i(isa_pkg::OP_SLTIU, 5'd0, ctrl_pkg::ALU_SLTU, ctrl_pkg::EXT_SIGNED);
		add_mem(isa_pkg::OP_LH, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_H);
		add_mem(isa_pkg::OP_LB, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_B);
		add_mem(isa_pkg::OP_SH, 5'd0, isa_pkg::CLS_STORE, ctrl_pkg::DM_H);
		add_mem(isa_pkg::OP_SB, 5'd0, isa_pkg::CLS_STORE, ctrl_pkg::DM_B);
		add_mem(isa_pkg::OP_LW, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_W);
		add_r(isa_pkg::FUNCT_ADDU, 5'd0, F_RS1, ctrl_pkg::ALU_ADDU); // Load-use on rs
		add_mem(isa_pkg::OP_LH, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_H);
		add_mem(isa_pkg::OP_SW, F_RT1, isa_pkg::CLS_STORE, ctrl_pkg::DM_W); // Data waits
		add_mem(isa_pkg::OP_LBU, F_RT0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_BU);
		add_r(isa_pkg::FUNCT_OR, 5'd0, F_RS1, ctrl_pkg::ALU_OR); // r0 never stalls
		add_mem(isa_pkg::OP_LW, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_W);
		add_cal_i(isa_pkg::OP_ANDI, 5'd0, ctrl_pkg::ALU_AND, ctrl_pkg::EXT_UNSIGNED);
		add_r(isa_pkg::FUNCT_SUBU, 5'd0, F_RT2, ctrl_pkg::ALU_SUBU); // Load result from W
		add_mem(isa_pkg::OP_LHU, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_HU);
		add_cal_i(isa_pkg::OP_ADDIU, F_RS1, ctrl_pkg::ALU_ADDU, ctrl_pkg::EXT_SIGNED);
		add_mem(isa_pkg::OP_LW, 5'd0, isa_pkg::CLS_LOAD, ctrl_pkg::DM_W);
		add_bad(isa_pkg::OP_SPECIAL, isa_pkg::FUNCT_SLL, 5'd7, F_RS1 | F_BAD_RS);
		add_bad(isa_pkg::OP_SPECIAL, isa_pkg::FUNCT_ADD, 5'd3, 5'd0);
		add_bad(isa_pkg::OP_LUI, 6'd0, 5'd0, F_BAD_RS);
		add_bad(6'b111111, 6'd0, 5'd0, 5'd0);
		add_bad(isa_pkg::OP_SPECIAL, 6'b001000, 5'd0, 5'd0); // JR was dropped
		add_r(isa_pkg::FUNCT_XOR, 5'd0, F_RS1, ctrl_pkg::ALU_XOR);

		sd = BUBBLE;
		se = BUBBLE;
		sm = BUBBLE;
		sw = BUBBLE;
		next_e = BUBBLE;
		exp_stall = 1'b0;

		// All late stages hold bubbles during reset
		@(negedge clk);
		while (rst_n !== 1'b1) begin
			check("alu_src", 32'(alu_src), 32'h0, BUBBLE);
			check("dm_write_enable", 32'(dm_write_enable), 32'h0, BUBBLE);
			check("dm_mode", 32'(dm_mode), 32'(ctrl_pkg::DM_NONE), BUBBLE);
			check("rf_write_enable", 32'(rf_write_enable), 32'h0, BUBBLE);
			check("regdata_sel", 32'(regdata_sel), 32'(ctrl_pkg::RD_NONE), BUBBLE);
			check("stall", 32'(stall), 32'h0, BUBBLE);
			@(negedge clk);
		end
		reset_err = errors;
		tests_run++;
		if (reset_err == 0) begin
			$display("test reset: ok");
		end else begin
			tests_failed++;
			$display("test reset: FAIL, %0d errors", reset_err);
		end

		i = 0;
		drain = 0;
		held = 1'b0;
		dst1 = 5'd0;
		dst2 = 5'd0;
		while (drain < 4) begin
			if (i < tbl.size()) begin
				if (!held) begin
					words.push_back(build_word(tbl[i], dst1, dst2));
					entry_err.push_back(0);
					sd = decode_slot(tbl[i], words[i], i);
				end
			end else begin
				sd = BUBBLE; // The idle word decodes to nothing
			end
			@(posedge clk);
			d_instr <= (i < tbl.size()) ? words[i] : IDLE_WORD;
			sw = sm;
			sm = se;
			se = next_e;
			@(negedge clk);
			exp_stall = (se.cls == isa_pkg::CLS_LOAD) && (se.regw != 5'd0) &&
				((se.regw == sd.reg1) || (se.regw == sd.reg2));
			compare_outputs();
			next_e = exp_stall ? BUBBLE : sd;
			if (i < tbl.size()) begin
				held = exp_stall;
				if (!exp_stall) begin
					dst2 = dst1;
					dst1 = sd.regw;
					i++;
				end
			end else begin
				drain++;
			end
		end

		$display("Tests: %0d run, %0d passed, %0d failed, %0d failed checks", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Each entry gets 20 cycles, on top of the reset time
	initial begin
		#1;
		#(CLK_PERIOD * (20 * tbl.size() + 10));
		$display("Watchdog expired before the table was done");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- pipe_control.f
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_classifier.sv
hdl/decode_ctrl.sv
hdl/stage_pipe.sv
hdl/late_stage_ctrl.sv
hdl/hazard_unit.sv
hdl/pipe_control.sv
dv/clk_gen.sv
dv/tb_pipe_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pipe_control -f pipe_control.f \
	-Mdir obj_dir -o sim_pipe_control > build.log 2>&1 \
	&& ./obj_dir/sim_pipe_control > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^All tests passed$" sim.log && exit 0 || exit 1
